// File: common/cdctl_settings.svh
// =========================================================================
// Build-time constants of the serial-bus controller. Included by the
// package and by every block that needs a width, an address or a reset
// value.
// =========================================================================
`ifndef CDCTL_SETTINGS_SVH
`define CDCTL_SETTINGS_SVH

// Register bus widths.
`define CDCTL_ADDR_W 5
`define CDCTL_DATA_W 8

// Upper five bits of the 7-bit I2C device address; addr_sel fills the rest.
`define CDCTL_I2C_BASE 5'b11001

// Reset baud divider. A bit lasts divider plus one clocks.
`define CDCTL_BAUD_RESET 8'd7

// Value returned by the VERSION register.
`define CDCTL_VERSION 8'h10

`endif

// File: common/cdctl_pkg.sv
// =========================================================================
// Shared types of the controller: register bus address and data words,
// and the register map of the link controller.
// =========================================================================
`include "cdctl_settings.svh"

package cdctl_pkg;

    typedef logic [`CDCTL_ADDR_W-1:0] csr_addr_t;
    typedef logic [`CDCTL_DATA_W-1:0] csr_data_t;

    // Register map. Addresses outside this list read as zero.
    typedef enum csr_addr_t {
        REG_VERSION = 0,
        REG_SETTING = 1,
        REG_BAUD    = 2,
        REG_STATUS  = 3,
        REG_TX_DATA = 4,
        REG_RX_DATA = 5,
        REG_SCRATCH = 6
    } reg_e;

endpackage

// File: common/csr_if.sv
// =========================================================================
// Register bus between a serial target (host side) and the register bank
// (target side). Strobes last one cycle; readdata follows a read by one.
// =========================================================================
`timescale 1ns/1ps

interface csr_if;
    cdctl_pkg::csr_addr_t address;
    logic                 read;
    logic                 write;
    cdctl_pkg::csr_data_t writedata;
    cdctl_pkg::csr_data_t readdata;

    modport host (
        output address,
        output read,
        output write,
        output writedata,
        input  readdata
    );

    modport target (
        input  address,
        input  read,
        input  write,
        input  writedata,
        output readdata
    );
endinterface

// File: spi_slave/spi_slave.sv
// =========================================================================
// SPI mode-0 target, MSB first. Byte one is {wr, 2'b0, addr[4:0]}; on a
// write byte two is the data, on a read the register is shifted out.
// =========================================================================
`timescale 1ns/1ps
`include "cdctl_settings.svh"

module spi_slave (
    input  logic clk,
    input  logic reset,
    input  logic sck,
    input  logic nss,
    input  logic sdi,
    output logic sdo,
    output logic sdo_en,
    csr_if.host  bus
);
    logic [2:0]           sck_sync;
    logic [1:0]           nss_sync;
    logic [1:0]           sdi_sync;
    logic                 nss_s;
    logic                 sck_rise;
    logic                 sck_fall;
    logic [3:0]           bit_cnt;
    logic [6:0]           rx_sh;
    cdctl_pkg::csr_data_t rx_byte;
    cdctl_pkg::csr_data_t tx_sh;
    logic                 is_write;
    logic                 rd_phase;
    logic                 rd_pend;

    // Two synchronizer stages; sck gets a third flop for edge detection.
    always_ff @(posedge clk) begin
        if (reset) begin
            sck_sync <= 3'b000;
            nss_sync <= 2'b11;
        end else begin
            sck_sync <= {sck_sync[1:0], sck};
            nss_sync <= {nss_sync[0], nss};
        end
        sdi_sync <= {sdi_sync[0], sdi};
    end

    assign nss_s    = nss_sync[1];
    assign sck_rise = sck_sync[1] & ~sck_sync[2];
    assign sck_fall = ~sck_sync[1] & sck_sync[2];
    assign rx_byte  = {rx_sh, sdi_sync[1]};

    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt   <= '0;
            is_write  <= 1'b0;
            rd_phase  <= 1'b0;
            rd_pend   <= 1'b0;
            sdo_en    <= 1'b0;
            bus.read  <= 1'b0;
            bus.write <= 1'b0;
        end else begin
            bus.read  <= 1'b0;
            bus.write <= 1'b0;
            rd_pend   <= bus.read;
            if (nss_s) begin
                bit_cnt  <= '0;
                rd_phase <= 1'b0;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 4'd1;
                // Command byte complete on the 8th edge.
                if (bit_cnt == 4'd7) begin
                    is_write <= rx_byte[7];
                    bus.read <= ~rx_byte[7];
                    rd_phase <= ~rx_byte[7];
                end
                if (bit_cnt == 4'd15) begin
                    bus.write <= is_write;
                    rd_phase  <= 1'b0;
                end
            end
            // Release on the first sign of nss so the pin is free once the
            // synchronized nss goes high.
            if (nss_sync[0] | nss_sync[1]) begin
                sdo_en <= 1'b0;
            end else if (sck_fall) begin
                sdo_en <= rd_phase;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sck_rise) begin
            rx_sh <= rx_byte[6:0];
        end
        if (sck_rise && bit_cnt == 4'd7) begin
            bus.address <= rx_byte[`CDCTL_ADDR_W-1:0];
        end
        if (sck_rise && bit_cnt == 4'd15) begin
            bus.writedata <= rx_byte;
        end
        if (rd_pend) begin
            tx_sh <= bus.readdata;
        end else if (sck_fall && rd_phase) begin
            sdo   <= tx_sh[7];
            tx_sh <= {tx_sh[6:0], 1'b0};
        end
    end

    a_sdo_idle: assert property (@(posedge clk) disable iff (reset) nss_s |-> !sdo_en)
        else $error("spi_slave: sdo_en high while nss is high");

endmodule

// File: i2c_slave/i2c_slave.sv
// =========================================================================
// I2C target. Address is {CDCTL_I2C_BASE, addr_sel}. The first written
// byte sets the register pointer; further writes and all reads use the
// pointer and step it by one.
// =========================================================================
`timescale 1ns/1ps
`include "cdctl_settings.svh"

module i2c_slave (
    input  logic       clk,
    input  logic       reset,
    input  logic       scl,
    input  logic       sda_in,
    input  logic [1:0] addr_sel,
    output logic       sda_en,
    csr_if.host        bus
);
    typedef enum logic [1:0] {ST_IDLE, ST_ADDR, ST_WDATA, ST_RDATA} state_t;

    state_t               state;
    logic [2:0]           scl_sync;
    logic [2:0]           sda_sync;
    logic                 scl_rise;
    logic                 scl_fall;
    logic                 start_det;
    logic                 stop_det;
    logic                 addr_match;
    logic [3:0]           bit_cnt;
    logic                 got_ptr;
    logic                 rd_pend;
    cdctl_pkg::csr_addr_t ptr;
    cdctl_pkg::csr_data_t shreg;
    cdctl_pkg::csr_data_t tx_sh;

    always_ff @(posedge clk) begin
        if (reset) begin
            scl_sync <= 3'b111;
            sda_sync <= 3'b111;
        end else begin
            scl_sync <= {scl_sync[1:0], scl};
            sda_sync <= {sda_sync[1:0], sda_in};
        end
    end

    assign scl_rise   = scl_sync[1] & ~scl_sync[2];
    assign scl_fall   = ~scl_sync[1] & scl_sync[2];
    // SDA moving while SCL stays high marks START or STOP.
    assign start_det  = scl_sync[1] & scl_sync[2] & sda_sync[2] & ~sda_sync[1];
    assign stop_det   = scl_sync[1] & scl_sync[2] & ~sda_sync[2] & sda_sync[1];
    assign addr_match = shreg[7:1] == {`CDCTL_I2C_BASE, addr_sel};

    // =====================================================================
    // Byte framing. bit_cnt counts SCL rises; the 9th is the ACK slot.
    // =====================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            bit_cnt   <= '0;
            got_ptr   <= 1'b0;
            ptr       <= '0;
            rd_pend   <= 1'b0;
            sda_en    <= 1'b0;
            bus.read  <= 1'b0;
            bus.write <= 1'b0;
        end else begin
            bus.read  <= 1'b0;
            bus.write <= 1'b0;
            rd_pend   <= bus.read;
            if (start_det) begin
                state   <= ST_ADDR;
                bit_cnt <= '0;
                sda_en  <= 1'b0;
            end else if (stop_det) begin
                state  <= ST_IDLE;
                sda_en <= 1'b0;
            end else if (state != ST_IDLE && scl_rise) begin
                if (bit_cnt != 4'd8) begin
                    bit_cnt <= bit_cnt + 4'd1;
                end else begin
                    bit_cnt <= '0;
                    case (state)
                        ST_ADDR: begin
                            // The address byte has been acked; pick the direction.
                            got_ptr <= 1'b0;
                            if (!addr_match) begin
                                state <= ST_IDLE;
                            end else if (shreg[0]) begin
                                state    <= ST_RDATA;
                                bus.read <= 1'b1;
                                ptr      <= ptr + 1'b1;
                            end else begin
                                state <= ST_WDATA;
                            end
                        end
                        ST_WDATA: begin
                            got_ptr <= 1'b1;
                            if (got_ptr) begin
                                bus.write <= 1'b1;
                                ptr       <= ptr + 1'b1;
                            end else begin
                                ptr <= shreg[`CDCTL_ADDR_W-1:0];
                            end
                        end
                        ST_RDATA: begin
                            // Host ACK asks for another byte, NACK ends the read.
                            if (!sda_sync[1]) begin
                                bus.read <= 1'b1;
                                ptr      <= ptr + 1'b1;
                            end else begin
                                state <= ST_IDLE;
                            end
                        end
                        default: ;
                    endcase
                end
            end else if (state != ST_IDLE && scl_fall) begin
                if (bit_cnt == 4'd8) begin
                    case (state)
                        ST_ADDR:  sda_en <= addr_match;
                        ST_WDATA: sda_en <= 1'b1;
                        default:  sda_en <= 1'b0;
                    endcase
                end else begin
                    sda_en <= (state == ST_RDATA) & ~tx_sh[3'd7 - bit_cnt[2:0]];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (scl_rise && bit_cnt != 4'd8) begin
            shreg <= {shreg[6:0], sda_sync[1]};
        end
        if (rd_pend) begin
            tx_sh <= bus.readdata;
        end
        bus.address   <= ptr;
        bus.writedata <= shreg;
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (reset)
        !(bus.read && bus.write))
        else $error("i2c_slave: read and write strobes together");

endmodule

// File: cdbus/cdbus_csr.sv
// =========================================================================
// Register bank of the link controller. Decodes the register map, keeps
// the receive flags and raises irq for a pending byte when enabled.
// =========================================================================
`timescale 1ns/1ps
`include "cdctl_settings.svh"

module cdbus_csr (
    input  logic                 clk,
    input  logic                 reset,
    csr_if.target                bus,
    input  logic                 tx_busy,
    input  logic                 rx_valid,
    input  cdctl_pkg::csr_data_t rx_byte,
    output logic                 tx_start,
    output cdctl_pkg::csr_data_t tx_byte,
    output cdctl_pkg::csr_data_t baud,
    output logic                 irq
);
    cdctl_pkg::csr_data_t setting;
    cdctl_pkg::csr_data_t scratch;
    cdctl_pkg::csr_data_t rx_data;
    logic                 rx_ready;
    logic                 rx_overrun;
    logic                 wr_tx;
    logic                 rd_rx;

    assign wr_tx = bus.write && bus.address == cdctl_pkg::REG_TX_DATA;
    assign rd_rx = bus.read && bus.address == cdctl_pkg::REG_RX_DATA;
    assign irq   = rx_ready & setting[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            setting    <= '0;
            baud       <= `CDCTL_BAUD_RESET;
            scratch    <= '0;
            tx_start   <= 1'b0;
            rx_ready   <= 1'b0;
            rx_overrun <= 1'b0;
        end else begin
            if (bus.write) begin
                case (bus.address)
                    cdctl_pkg::REG_SETTING: setting <= bus.writedata;
                    cdctl_pkg::REG_BAUD:    baud    <= bus.writedata;
                    cdctl_pkg::REG_SCRATCH: scratch <= bus.writedata;
                    default: ;
                endcase
            end
            // A frame already under way, or about to start, drops the write.
            tx_start <= wr_tx && !tx_busy && !tx_start;
            if (rd_rx) begin
                rx_ready   <= 1'b0;
                rx_overrun <= 1'b0;
            end
            if (rx_valid) begin
                rx_ready <= 1'b1;
                if (rx_ready && !rd_rx) begin
                    rx_overrun <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_tx && !tx_busy && !tx_start) begin
            tx_byte <= bus.writedata;
        end
        if (rx_valid) begin
            rx_data <= rx_byte;
        end
        if (bus.read) begin
            case (bus.address)
                cdctl_pkg::REG_VERSION: bus.readdata <= `CDCTL_VERSION;
                cdctl_pkg::REG_SETTING: bus.readdata <= setting;
                cdctl_pkg::REG_BAUD:    bus.readdata <= baud;
                cdctl_pkg::REG_STATUS:  bus.readdata <= {5'b0, rx_overrun, tx_busy, rx_ready};
                cdctl_pkg::REG_RX_DATA: bus.readdata <= rx_data;
                cdctl_pkg::REG_SCRATCH: bus.readdata <= scratch;
                default:                bus.readdata <= '0;
            endcase
        end
    end

    a_no_start_busy: assert property (@(posedge clk) disable iff (reset)
        tx_start |-> !tx_busy)
        else $error("cdbus_csr: tx_start while tx_busy");

endmodule

// File: cdbus/cdbus_serial.sv
// =========================================================================
// Serial line engine: 8N1 transmitter with RS-485 driver enable and a
// receiver that samples in the middle of each bit.
// =========================================================================
`timescale 1ns/1ps

module cdbus_serial (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 tx_start,
    input  cdctl_pkg::csr_data_t tx_byte,
    input  cdctl_pkg::csr_data_t baud,
    input  logic                 rx,
    output logic                 tx,
    output logic                 tx_en,
    output logic                 tx_busy,
    output logic                 rx_valid,
    output cdctl_pkg::csr_data_t rx_byte
);
    cdctl_pkg::csr_data_t tx_cnt;
    cdctl_pkg::csr_data_t rx_cnt;
    cdctl_pkg::csr_data_t rx_target;
    logic [3:0]           tx_bit;
    logic [3:0]           rx_bit;
    logic [8:0]           tx_sh;
    cdctl_pkg::csr_data_t rx_sh;
    logic [2:0]           rx_sync;
    logic                 rx_busy;

    // =====================================================================
    // Transmitter. Start bit, 8 data bits LSB first, stop bit.
    // =====================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            tx      <= 1'b1;
            tx_en   <= 1'b0;
            tx_busy <= 1'b0;
            tx_cnt  <= '0;
            tx_bit  <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx      <= 1'b0;
                tx_en   <= 1'b1;
                tx_busy <= 1'b1;
                tx_cnt  <= '0;
                tx_bit  <= '0;
                tx_sh   <= {1'b1, tx_byte};
            end
        end else if (tx_cnt != baud) begin
            tx_cnt <= tx_cnt + 1'b1;
        end else begin
            tx_cnt <= '0;
            if (tx_bit == 4'd9) begin
                tx      <= 1'b1;
                tx_en   <= 1'b0;
                tx_busy <= 1'b0;
            end else begin
                tx     <= tx_sh[0];
                tx_sh  <= {1'b0, tx_sh[8:1]};
                tx_bit <= tx_bit + 4'd1;
            end
        end
    end

    // =====================================================================
    // Receiver. Half a bit to the start-bit centre, then a full bit each.
    // =====================================================================
    assign rx_target = (rx_bit == 4'd0) ? {1'b0, baud[7:1]} : baud;

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_sync  <= 3'b111;
            rx_busy  <= 1'b0;
            rx_valid <= 1'b0;
            rx_cnt   <= '0;
            rx_bit   <= '0;
        end else begin
            rx_sync  <= {rx_sync[1:0], rx};
            rx_valid <= 1'b0;
            if (!rx_busy) begin
                if (rx_sync[2] && !rx_sync[1]) begin
                    rx_busy <= 1'b1;
                    rx_cnt  <= '0;
                    rx_bit  <= '0;
                end
            end else if (rx_cnt != rx_target) begin
                rx_cnt <= rx_cnt + 1'b1;
            end else begin
                rx_cnt <= '0;
                rx_bit <= rx_bit + 4'd1;
                if (rx_bit == 4'd0 && rx_sync[1]) begin
                    // Glitch, not a start bit.
                    rx_busy <= 1'b0;
                end else if (rx_bit == 4'd9) begin
                    rx_busy  <= 1'b0;
                    rx_valid <= rx_sync[1];
                end else if (rx_bit != 4'd0) begin
                    rx_sh <= {rx_sync[1], rx_sh[7:1]};
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_busy && rx_bit == 4'd9 && rx_cnt == rx_target && rx_sync[1]) begin
            rx_byte <= rx_sh;
        end
    end

    a_tx_driven: assert property (@(posedge clk) disable iff (reset) !tx |-> tx_en)
        else $error("cdbus_serial: tx low without tx_en");

endmodule

// File: design/cdctl_top.sv
// =========================================================================
// Controller top level. intf_sel picks SPI (1) or I2C (0) as the host of
// the register bank; the link controller sits behind the bank.
// =========================================================================
`timescale 1ns/1ps

module cdctl_top (
    input  logic       clk,
    input  logic       reset,
    input  logic       intf_sel,
    input  logic [1:0] addr_sel,
    input  logic       sdi,
    inout  wire        sdo_sda,
    input  logic       sck_scl,
    input  logic       nss,
    input  logic       rx,
    output logic       tx,
    output logic       tx_en,
    output wire        int_n
);
    csr_if spi_bus ();
    csr_if i2c_bus ();
    csr_if ctl_bus ();

    logic                 sdo;
    logic                 sdo_en;
    logic                 sda_en;
    logic                 irq;
    logic                 tx_start;
    logic                 tx_busy;
    logic                 rx_valid;
    cdctl_pkg::csr_data_t tx_byte;
    cdctl_pkg::csr_data_t baud;
    cdctl_pkg::csr_data_t rx_byte;

    // Bus steering. The pin selects one host, so no arbitration is needed.
    assign ctl_bus.address   = intf_sel ? spi_bus.address   : i2c_bus.address;
    assign ctl_bus.read      = intf_sel ? spi_bus.read      : i2c_bus.read;
    assign ctl_bus.write     = intf_sel ? spi_bus.write     : i2c_bus.write;
    assign ctl_bus.writedata = intf_sel ? spi_bus.writedata : i2c_bus.writedata;
    assign spi_bus.readdata  = ctl_bus.readdata;
    assign i2c_bus.readdata  = ctl_bus.readdata;

    // Shared data pin. The I2C side is open drain.
    assign sdo_sda = intf_sel ? (sdo_en ? sdo : 1'bz) : (sda_en ? 1'b0 : 1'bz);
    assign int_n   = irq ? 1'b0 : 1'bz;

    // The unselected target sees an idle bus.
    spi_slave u_spi (
        .clk    (clk),
        .reset  (reset),
        .sck    (intf_sel ? sck_scl : 1'b1),
        .nss    (intf_sel ? nss : 1'b1),
        .sdi    (sdi),
        .sdo    (sdo),
        .sdo_en (sdo_en),
        .bus    (spi_bus.host)
    );

    i2c_slave u_i2c (
        .clk      (clk),
        .reset    (reset),
        .scl      (intf_sel ? 1'b1 : sck_scl),
        .sda_in   (intf_sel | sdo_sda),
        .addr_sel (addr_sel),
        .sda_en   (sda_en),
        .bus      (i2c_bus.host)
    );

    cdbus_csr u_csr (
        .clk      (clk),
        .reset    (reset),
        .bus      (ctl_bus.target),
        .tx_busy  (tx_busy),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .baud     (baud),
        .irq      (irq)
    );

    cdbus_serial u_serial (
        .clk      (clk),
        .reset    (reset),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .baud     (baud),
        .rx       (rx),
        .tx       (tx),
        .tx_en    (tx_en),
        .tx_busy  (tx_busy),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte)
    );

endmodule

// File: bench/cdctl_tb.sv
// =========================================================================
// Testbench of the serial-bus controller. Drives the SPI, I2C and rx pins,
// watches tx, tx_en and int_n, and checks each result with an assertion.
// =========================================================================
`timescale 1ns/1ps
`include "cdctl_settings.svh"

module cdctl_tb;
    // Budget for the watchdog, in clocks.
    localparam int SPI_CYC   = 8 + 16 * 16 + 16;
    localparam int I2C_CYC   = 9 * 16;
    localparam int FRAME_CYC = 10 * 64;
    localparam int TEST_CYC  = 14 * SPI_CYC + 14 * I2C_CYC + 6 * FRAME_CYC;

    logic        clk = 1'b0;
    logic        reset;
    logic        intf_sel;
    logic [1:0]  addr_sel;
    logic        sdi;
    logic        sck_scl;
    logic        nss;
    logic        rx;
    logic        tx;
    logic        tx_en;
    logic        sda_low;
    wire         sdo_sda;
    wire         int_n;

    logic [31:0] lfsr = 32'h6a54;
    int          errors = 0;
    int          checks = 0;

    logic [7:0]  rd;
    logic [7:0]  rd2;
    logic [7:0]  wr;
    logic [7:0]  wr2;
    logic [7:0]  baud_v;
    logic [4:0]  unmapped;
    logic [1:0]  sel_v;
    logic [6:0]  dev;
    logic [9:0]  frame;
    int          len;
    int          bit_len;
    int          high_cnt;

    // The host model only ever pulls SDA low.
    pullup pu_sda (sdo_sda);
    pullup pu_int (int_n);
    assign sdo_sda = sda_low ? 1'b0 : 1'bz;

    always #4 clk = ~clk;

    cdctl_top dut (
        .clk      (clk),
        .reset    (reset),
        .intf_sel (intf_sel),
        .addr_sel (addr_sel),
        .sdi      (sdi),
        .sdo_sda  (sdo_sda),
        .sck_scl  (sck_scl),
        .nss      (nss),
        .rx       (rx),
        .tx       (tx),
        .tx_en    (tx_en),
        .int_n    (int_n)
    );

    // =========================================================================
    // Random numbers and checking
    // =========================================================================
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken.
    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        int         i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic clocks(input int n);
        repeat (n) @(posedge clk);
    endtask

    // =========================================================================
    // SPI host, mode 0, clk/16
    // =========================================================================
    task automatic spi_transfer(input logic [7:0] cmd, input logic [7:0] data,
                                output logic [7:0] rdata);
        logic [15:0] word;
        int          i;
        word  = {cmd, data};
        rdata = '0;
        nss <= 1'b0;
        clocks(8);
        for (i = 15; i >= 0; i--) begin
            sdi <= word[i];
            clocks(7);
            @(negedge clk);
            if (i < 8) begin
                rdata[i] = sdo_sda;
            end
            @(posedge clk);
            sck_scl <= 1'b1;
            clocks(8);
            sck_scl <= 1'b0;
        end
        clocks(8);
        nss <= 1'b1;
        clocks(8);
    endtask

    task automatic spi_write(input logic [4:0] addr, input logic [7:0] data);
        logic [7:0] unused;
        spi_transfer({3'b100, addr}, data, unused);
    endtask

    task automatic spi_read(input logic [4:0] addr, output logic [7:0] data);
        spi_transfer({3'b000, addr}, 8'h00, data);
    endtask

    // =========================================================================
    // I2C host, clk/16
    // =========================================================================
    task automatic scl_bit(input logic b, output logic s);
        sda_low <= ~b;
        clocks(4);
        sck_scl <= 1'b1;
        clocks(3);
        @(negedge clk);
        s = sdo_sda;
        clocks(5);
        sck_scl <= 1'b0;
        clocks(4);
    endtask

    // Serves for a first START and for a repeated START.
    task automatic i2c_start();
        sda_low <= 1'b0;
        clocks(4);
        sck_scl <= 1'b1;
        clocks(4);
        sda_low <= 1'b1;
        clocks(4);
        sck_scl <= 1'b0;
        clocks(4);
    endtask

    task automatic i2c_stop();
        sda_low <= 1'b1;
        clocks(4);
        sck_scl <= 1'b1;
        clocks(4);
        sda_low <= 1'b0;
        clocks(8);
    endtask

    task automatic i2c_send(input logic [7:0] b, input logic want_ack);
        logic s;
        int   i;
        for (i = 7; i >= 0; i--) begin
            scl_bit(b[i], s);
        end
        scl_bit(1'b1, s);
        check_value("sdo_sda in ACK slot", 16'(s), 16'(!want_ack));
    endtask

    task automatic i2c_recv(input logic ack_it, output logic [7:0] b);
        logic s;
        int   i;
        for (i = 7; i >= 0; i--) begin
            scl_bit(1'b1, s);
            b[i] = s;
        end
        scl_bit(!ack_it, s);
    endtask

    // =========================================================================
    // Link line
    // =========================================================================
    // Samples tx in the middle of each bit and counts the clocks of tx_en.
    task automatic capture_frame(input int blen, output logic [9:0] bits, output int n);
        n    = 0;
        bits = '1;
        @(negedge clk);
        while (tx_en !== 1'b1) begin
            @(negedge clk);
        end
        while (tx_en === 1'b1) begin
            if (n % blen == blen / 2 && n / blen < 10) begin
                bits[n / blen] = tx;
            end
            n++;
            @(negedge clk);
        end
    endtask

    task automatic send_rx(input logic [7:0] b, input int blen);
        logic [9:0] bits;
        int         i;
        bits = {1'b1, b, 1'b0};
        for (i = 0; i < 10; i++) begin
            rx <= bits[i];
            clocks(blen);
        end
    endtask

    initial begin
        #(2 * TEST_CYC * 8);
        $display("Watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        reset    = 1'b1;
        intf_sel = 1'b1;
        addr_sel = 2'b00;
        sdi      = 1'b0;
        sck_scl  = 1'b0;
        nss      = 1'b1;
        rx       = 1'b1;
        sda_low  = 1'b0;
        clocks(3);
        reset <= 1'b0;
        clocks(4);

        // SPI register access.
        spi_read(cdctl_pkg::REG_VERSION, rd);
        check_value("VERSION", 16'(rd), 16'(`CDCTL_VERSION));
        wr = take_bits(8);
        spi_write(cdctl_pkg::REG_SCRATCH, wr);
        spi_read(cdctl_pkg::REG_SCRATCH, rd);
        check_value("SCRATCH", 16'(rd), 16'(wr));
        unmapped = 5'h10 + 5'(take_bits(4));
        spi_read(unmapped, rd);
        check_value("unmapped register", 16'(rd), 16'd0);

        // I2C with a random device address.
        sel_v = 2'(take_bits(2));
        intf_sel <= 1'b0;
        sck_scl  <= 1'b1;
        addr_sel <= sel_v;
        clocks(8);
        dev = {`CDCTL_I2C_BASE, sel_v};
        wr  = take_bits(8);
        wr2 = take_bits(8);
        i2c_start();
        i2c_send({dev, 1'b0}, 1'b1);
        i2c_send({3'b000, cdctl_pkg::REG_SETTING}, 1'b1);
        i2c_send(wr, 1'b1);
        i2c_send(wr2, 1'b1);
        i2c_stop();
        // Point back at SETTING, then read both bytes after a repeated START.
        i2c_start();
        i2c_send({dev, 1'b0}, 1'b1);
        i2c_send({3'b000, cdctl_pkg::REG_SETTING}, 1'b1);
        i2c_start();
        i2c_send({dev, 1'b1}, 1'b1);
        i2c_recv(1'b1, rd);
        i2c_recv(1'b0, rd2);
        i2c_stop();
        check_value("I2C read SETTING", 16'(rd), 16'(wr));
        check_value("I2C read BAUD", 16'(rd2), 16'(wr2));
        i2c_start();
        i2c_send({dev ^ 7'd1, 1'b0}, 1'b0);
        i2c_stop();

        intf_sel <= 1'b1;
        sck_scl  <= 1'b0;
        clocks(8);

        // One transmitted frame, STATUS read while it runs.
        baud_v  = 8'd48 + take_bits(4);
        bit_len = int'(baud_v) + 1;
        spi_write(cdctl_pkg::REG_BAUD, baud_v);
        wr = take_bits(8);
        fork
            capture_frame(bit_len, frame, len);
            begin
                spi_write(cdctl_pkg::REG_TX_DATA, wr);
                spi_read(cdctl_pkg::REG_STATUS, rd);
            end
        join
        check_value("tx frame", 16'(frame), 16'({1'b1, wr, 1'b0}));
        check_value("tx_en clocks", 16'(len), 16'(10 * bit_len));
        check_value("STATUS[1] during frame", 16'(rd[1]), 16'd1);

        // A second TX_DATA write during the frame is dropped.
        wr  = take_bits(8);
        wr2 = take_bits(8);
        clocks(1);
        fork
            capture_frame(bit_len, frame, len);
            begin
                spi_write(cdctl_pkg::REG_TX_DATA, wr);
                spi_write(cdctl_pkg::REG_TX_DATA, wr2);
            end
        join
        check_value("tx frame", 16'(frame), 16'({1'b1, wr, 1'b0}));
        high_cnt = 0;
        repeat (10 * bit_len) begin
            @(negedge clk);
            if (tx_en === 1'b1) begin
                high_cnt++;
            end
        end
        check_value("tx_en after dropped write", 16'(high_cnt), 16'd0);
        clocks(1);

        // Receive with the interrupt enabled.
        spi_write(cdctl_pkg::REG_SETTING, 8'h01);
        wr = take_bits(8);
        send_rx(wr, bit_len);
        @(negedge clk);
        check_value("int_n after receive", 16'(int_n), 16'd0);
        clocks(1);
        spi_read(cdctl_pkg::REG_RX_DATA, rd);
        check_value("RX_DATA", 16'(rd), 16'(wr));
        @(negedge clk);
        check_value("int_n after RX_DATA read", 16'(int_n), 16'd1);
        clocks(1);
        spi_read(cdctl_pkg::REG_STATUS, rd);
        check_value("STATUS[0] after read", 16'(rd[0]), 16'd0);

        // Two bytes without a read in between.
        wr  = take_bits(8);
        wr2 = take_bits(8);
        send_rx(wr, bit_len);
        send_rx(wr2, bit_len);
        spi_read(cdctl_pkg::REG_STATUS, rd);
        check_value("STATUS[2] after overrun", 16'(rd[2]), 16'd1);
        spi_read(cdctl_pkg::REG_RX_DATA, rd);
        check_value("RX_DATA after overrun", 16'(rd), 16'(wr2));

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+common
common/cdctl_pkg.sv
common/csr_if.sv
spi_slave/spi_slave.sv
i2c_slave/i2c_slave.sv
cdbus/cdbus_csr.sv
cdbus/cdbus_serial.sv
design/cdctl_top.sv
bench/cdctl_tb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module cdctl_tb -f all.f -o cdctl_sim &&
./obj_dir/cdctl_sim | tee /dev/stderr | grep -q "Simulation passed" &&
echo "PASS" || { echo "FAIL"; exit 1; }
